//--- hdl/conv_tiling_pkg.sv
package conv_tiling_pkg;

   ////////////////////////////////////////////////////////////
   // field widths
   ////////////////////////////////////////////////////////////

   localparam int DIM_W  = 16;
   localparam int KDIM_W = 4;

   // layer dimensions, tile starts and loop indices
   typedef logic [DIM_W-1:0] dim_t;

   // kernel size, stride and padding
   typedef logic [KDIM_W-1:0] kdim_t;

   // one extra bit so the padding region can go negative
   typedef logic signed [DIM_W:0] coord_t;

   ////////////////////////////////////////////////////////////
   // tile geometry
   ////////////////////////////////////////////////////////////

   // output columns covered by one tile
   localparam dim_t PIXELS_IN_ROW = 16'd32;

   // output channels per tile, 8 bit mode and 1 bit mode
   localparam dim_t ROWS_MODE0 = 16'd64;
   localparam dim_t ROWS_MODE1 = 16'd128;

   // output rows per tile, one per line buffer
   localparam dim_t BUFFERS_NUM = 16'd3;

endpackage

//--- hdl/tile_if.sv
`timescale 1ns/1ps

interface tile_if;
   import conv_tiling_pkg::*;

   // tile origin, all starts count from 1
   dim_t ox_start;
   dim_t oy_start;
   dim_t of_start;
   dim_t if_idx;

   // tile extent, clipped at the layer edge
   dim_t pox;
   dim_t poy;
   dim_t pof;

   // y tile number from 0
   dim_t row_base;

   modport ctrl (
      output ox_start, oy_start, of_start, if_idx,
      output pox, poy, pof, row_base
   );

   modport user (
      input ox_start, oy_start, of_start, if_idx,
      input pox, poy, pof, row_base
   );

endinterface

//--- hdl/row_step_if.sv
`timescale 1ns/1ps

interface row_step_if;
   import conv_tiling_pkg::*;

   logic  run;
   logic  step_valid;
   kdim_t ky;
   // last kernel row of the current pass
   logic  pass_done;

   // loop controller only looks at the end of each pass
   modport ctrl (output run, input pass_done);

   modport seq (input run, output step_valid, ky, pass_done);

   // datapath blocks follow the row steps
   modport user (input step_valid, ky);

endinterface

//--- hdl/conv_tiling.sv
`timescale 1ns/1ps

module conv_tiling (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  start,
   input  logic                  mode,
   input  conv_tiling_pkg::dim_t of,
   input  conv_tiling_pkg::dim_t ox,
   input  conv_tiling_pkg::dim_t oy,
   input  conv_tiling_pkg::dim_t nif,
   output logic                  busy,
   output logic                  done,
   tile_if.ctrl                  tile,
   row_step_if.ctrl              step
);
   import conv_tiling_pkg::*;

   dim_t row_num;
   dim_t if_cnt;
   dim_t f_start;
   dim_t x_start;
   dim_t y_start;
   dim_t y_tiles;
   logic if_end;
   logic f_end;
   logic x_end;
   logic y_end;

   // true when base + inc runs past limit, done in 17 bits
   function automatic logic past_limit(dim_t base, dim_t inc, dim_t limit);
      logic [DIM_W:0] sum;
      sum = {1'b0, base} + {1'b0, inc};
      return sum > {1'b0, limit};
   endfunction

   // tile extent, cut short on the last tile of a dimension
   function automatic dim_t clip(dim_t base, dim_t size, dim_t limit);
      logic [DIM_W:0] last;
      last = {1'b0, base} + {1'b0, size} - {{DIM_W{1'b0}}, 1'b1};
      if (last > {1'b0, limit})
         return limit - base + dim_t'(1);
      return size;
   endfunction

   assign row_num = mode ? ROWS_MODE1 : ROWS_MODE0;

   ////////////////////////////////////////////////////////////
   // loop chain, input channel innermost
   ////////////////////////////////////////////////////////////

   // each wrap enables the next loop outward
   assign if_end = step.pass_done && past_limit(if_cnt, dim_t'(1), nif);
   assign f_end  = if_end && past_limit(f_start, row_num, of);
   assign x_end  = f_end && past_limit(x_start, PIXELS_IN_ROW, ox);
   assign y_end  = x_end && past_limit(y_start, BUFFERS_NUM, oy);

   always_ff @(posedge clk) begin
      if (reset) begin
         if_cnt  <= dim_t'(1);
         f_start <= dim_t'(1);
         x_start <= dim_t'(1);
         y_start <= dim_t'(1);
         y_tiles <= '0;
      end else if (step.pass_done) begin
         if_cnt <= if_end ? dim_t'(1) : if_cnt + dim_t'(1);
         if (if_end) begin
            f_start <= f_end ? dim_t'(1) : f_start + row_num;
         end
         if (f_end) begin
            x_start <= x_end ? dim_t'(1) : x_start + PIXELS_IN_ROW;
         end
         if (x_end) begin
            if (y_end) begin
               y_start <= dim_t'(1);
               y_tiles <= '0;
            end else begin
               y_start <= y_start + BUFFERS_NUM;
               y_tiles <= y_tiles + dim_t'(1);
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // run control
   ////////////////////////////////////////////////////////////

   // start while busy changes nothing
   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
      end else if (y_end) begin
         busy <= 1'b0;
      end else if (start) begin
         busy <= 1'b1;
      end
   end

   assign step.run = busy;

   // last pass of the last tile
   assign done = y_end;

   // descriptor
   assign tile.ox_start = x_start;
   assign tile.oy_start = y_start;
   assign tile.of_start = f_start;
   assign tile.if_idx   = if_cnt;
   assign tile.row_base = y_tiles;

   assign tile.pox = clip(x_start, PIXELS_IN_ROW, ox);
   assign tile.poy = clip(y_start, BUFFERS_NUM, oy);
   assign tile.pof = clip(f_start, row_num, of);

endmodule

//--- hdl/kernel_row_sequencer.sv
`timescale 1ns/1ps

module kernel_row_sequencer (
   input  logic                   clk,
   input  logic                   reset,
   input  conv_tiling_pkg::kdim_t k,
   row_step_if.seq                step
);
   import conv_tiling_pkg::*;

   kdim_t ky_q;
   kdim_t ky_last;
   logic  last_row;

   // a kernel of size 0 behaves as a single row
   assign ky_last  = (k == '0) ? '0 : k - kdim_t'(1);
   assign last_row = (ky_q == ky_last);

   ////////////////////////////////////////////////////////////
   // row counter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         ky_q <= '0;
      end else if (!step.run) begin
         // idle, next run begins at row 0
         ky_q <= '0;
      end else if (last_row) begin
         ky_q <= '0;
      end else begin
         ky_q <= ky_q + kdim_t'(1);
      end
   end

   // one row step per cycle, no stalls
   assign step.step_valid = step.run;
   assign step.ky         = ky_q;

   // pass ends on the last kernel row
   assign step.pass_done = step.run && last_row;

endmodule

//--- hdl/input_window_calc.sv
`timescale 1ns/1ps

module input_window_calc (
   input  logic                    clk,
   input  logic                    reset,
   input  conv_tiling_pkg::dim_t   ix,
   input  conv_tiling_pkg::dim_t   iy,
   input  conv_tiling_pkg::kdim_t  s,
   input  conv_tiling_pkg::kdim_t  p,
   tile_if.user                    tile,
   row_step_if.user                step,
   output logic                    fetch_valid,
   output conv_tiling_pkg::coord_t fetch_row,
   output conv_tiling_pkg::coord_t fetch_col,
   output logic                    fetch_pad
);
   import conv_tiling_pkg::*;

   coord_t row_c;
   coord_t col_c;
   logic   row_out;
   logic   col_out;

   // window origin of row 0 of the tile, shifted by the kernel row
   assign row_c = (coord_t'(tile.oy_start) - coord_t'(1)) * coord_t'(s)
                  + coord_t'(step.ky) - coord_t'(p);
   assign col_c = (coord_t'(tile.ox_start) - coord_t'(1)) * coord_t'(s)
                  - coord_t'(p);

   // outside the input map means zero padding
   assign row_out = (row_c < 0) || (row_c >= coord_t'(iy));
   assign col_out = (col_c < 0) || (col_c >= coord_t'(ix));

   always_ff @(posedge clk) begin
      if (reset) begin
         fetch_valid <= 1'b0;
      end else begin
         fetch_valid <= step.step_valid;
      end
   end

   // record payload, held between steps
   always_ff @(posedge clk) begin
      if (step.step_valid) begin
         fetch_row <= row_c;
         fetch_col <= col_c;
         fetch_pad <= row_out || col_out;
      end
   end

endmodule

//--- hdl/weight_addr_calc.sv
`timescale 1ns/1ps

module weight_addr_calc (
   input  logic                   clk,
   input  conv_tiling_pkg::dim_t  nif,
   input  conv_tiling_pkg::kdim_t k,
   tile_if.user                   tile,
   row_step_if.user               step,
   output conv_tiling_pkg::dim_t  weight_addr
);
   import conv_tiling_pkg::*;

   dim_t kernel_idx;
   dim_t addr_next;

   // weights laid out as [of][if][ky], one word per kernel row
   // all terms wrap at 16 bits like the address bus
   assign kernel_idx = (tile.of_start - dim_t'(1)) * nif
                       + tile.if_idx - dim_t'(1);
   assign addr_next  = kernel_idx * dim_t'(k) + dim_t'(step.ky);

   // lines up with the window record, one cycle after the step
   always_ff @(posedge clk) begin
      if (step.step_valid) begin
         weight_addr <= addr_next;
      end
   end

endmodule

//--- hdl/conv_tile_engine.sv
`timescale 1ns/1ps

module conv_tile_engine (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    start,
   input  logic                    mode,
   input  conv_tiling_pkg::dim_t   of,
   input  conv_tiling_pkg::dim_t   ox,
   input  conv_tiling_pkg::dim_t   oy,
   input  conv_tiling_pkg::dim_t   ix,
   input  conv_tiling_pkg::dim_t   iy,
   input  conv_tiling_pkg::dim_t   nif,
   input  conv_tiling_pkg::kdim_t  k,
   input  conv_tiling_pkg::kdim_t  s,
   input  conv_tiling_pkg::kdim_t  p,
   output logic                    busy,
   output logic                    done,
   output logic                    fetch_valid,
   output conv_tiling_pkg::coord_t fetch_row,
   output conv_tiling_pkg::coord_t fetch_col,
   output logic                    fetch_pad,
   output conv_tiling_pkg::dim_t   weight_addr,
   output conv_tiling_pkg::dim_t   ox_start,
   output conv_tiling_pkg::dim_t   oy_start,
   output conv_tiling_pkg::dim_t   of_start,
   output conv_tiling_pkg::dim_t   if_idx,
   output conv_tiling_pkg::dim_t   pox,
   output conv_tiling_pkg::dim_t   poy,
   output conv_tiling_pkg::dim_t   pof,
   output conv_tiling_pkg::dim_t   row_base
);

   tile_if     tile ();
   row_step_if step ();

   ////////////////////////////////////////////////////////////
   // loop control and row steps
   ////////////////////////////////////////////////////////////

   conv_tiling u_tiling (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .mode  (mode),
      .of    (of),
      .ox    (ox),
      .oy    (oy),
      .nif   (nif),
      .busy  (busy),
      .done  (done),
      .tile  (tile.ctrl),
      .step  (step.ctrl)
   );

   kernel_row_sequencer u_rows (
      .clk   (clk),
      .reset (reset),
      .k     (k),
      .step  (step.seq)
   );

   ////////////////////////////////////////////////////////////
   // fetch record
   ////////////////////////////////////////////////////////////

   input_window_calc u_window (
      .clk         (clk),
      .reset       (reset),
      .ix          (ix),
      .iy          (iy),
      .s           (s),
      .p           (p),
      .tile        (tile.user),
      .step        (step.user),
      .fetch_valid (fetch_valid),
      .fetch_row   (fetch_row),
      .fetch_col   (fetch_col),
      .fetch_pad   (fetch_pad)
   );

   weight_addr_calc u_weight (
      .clk         (clk),
      .nif         (nif),
      .k           (k),
      .tile        (tile.user),
      .step        (step.user),
      .weight_addr (weight_addr)
   );

   // current tile descriptor
   assign ox_start = tile.ox_start;
   assign oy_start = tile.oy_start;
   assign of_start = tile.of_start;
   assign if_idx   = tile.if_idx;
   assign pox      = tile.pox;
   assign poy      = tile.poy;
   assign pof      = tile.pof;
   assign row_base = tile.row_base;

endmodule

//--- sim/tb_conv_tile_engine.sv
`timescale 1ns/1ps

module tb_conv_tile_engine;
   import conv_tiling_pkg::*;

   localparam int NUM_LAYERS = 6;
   // tile geometry of the loop nest
   localparam int TILE_COLS = 32;
   localparam int TILE_ROWS = 3;
   localparam int CH_MODE0  = 64;
   localparam int CH_MODE1  = 128;

   typedef struct packed {
      logic        md;
      logic [15:0] of, ox, oy, ix, iy, nif;
      logic [3:0]  k, s, p;
   } layer_t;

   // descriptor and fetch record of one row step
   typedef struct packed {
      logic [15:0] ox_s, oy_s, of_s, if_i, pox, poy, pof, rb;
      int          row;
      int          col;
      logic        pad;
      logic [15:0] waddr;
   } step_t;

   logic   clk, reset, start, mode;
   dim_t   of, ox, oy, ix, iy, nif;
   kdim_t  k, s, p;
   logic   busy, done, fetch_valid, fetch_pad;
   coord_t fetch_row, fetch_col;
   dim_t   weight_addr, ox_start, oy_start, of_start, if_idx;
   dim_t   pox, poy, pof, row_base;

   step_t  exp_q[$];
   layer_t layers[NUM_LAYERS];
   int     step_idx;
   int     fetch_idx;
   int     done_count;
   int     budget_cycles = 0;

   conv_tile_engine u_conv_tile_engine (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic report_mismatch(input string msg);
      $display("mismatch at %0t: %s", $time, msg);
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   function automatic int ceil_div(input int a, input int b);
      return (a + b - 1) / b;
   endfunction

   function automatic int predicted_steps(input layer_t l);
      int ch;
      ch = l.md ? CH_MODE1 : CH_MODE0;
      return int'(l.k) * int'(l.nif) * ceil_div(int'(l.of), ch)
             * ceil_div(int'(l.ox), TILE_COLS) * ceil_div(int'(l.oy), TILE_ROWS);
   endfunction

   // extent of a tile that may hang over the layer edge
   function automatic logic [15:0] clipped(input int first, input int size, input int limit);
      return (limit - first + 1 < size) ? 16'(limit - first + 1) : 16'(size);
   endfunction

   function automatic layer_t make_layer(input logic md, input int f, x, y, xi, yi,
                                         input int n, kk, ss, pp);
      layer_t l;
      l = '{md, 16'(f), 16'(x), 16'(y), 16'(xi), 16'(yi), 16'(n), 4'(kk), 4'(ss), 4'(pp)};
      return l;
   endfunction

   ////////////////////////////////////////////////////////////
   // reference loop nest with input channel innermost
   ////////////////////////////////////////////////////////////

   task automatic build_model(input layer_t l);
      int    ch, y, x, f, i, ky;
      step_t e;
      ch = l.md ? CH_MODE1 : CH_MODE0;
      exp_q.delete();
      for (y = 1; y <= int'(l.oy); y += TILE_ROWS) begin
         for (x = 1; x <= int'(l.ox); x += TILE_COLS) begin
            for (f = 1; f <= int'(l.of); f += ch) begin
               for (i = 1; i <= int'(l.nif); i++) begin
                  for (ky = 0; ky < int'(l.k); ky++) begin
                     e.ox_s  = 16'(x);
                     e.oy_s  = 16'(y);
                     e.of_s  = 16'(f);
                     e.if_i  = 16'(i);
                     e.pox   = clipped(x, TILE_COLS, int'(l.ox));
                     e.poy   = clipped(y, TILE_ROWS, int'(l.oy));
                     e.pof   = clipped(f, ch, int'(l.of));
                     e.rb    = 16'((y - 1) / TILE_ROWS);
                     e.row   = (y - 1) * int'(l.s) + ky - int'(l.p);
                     e.col   = (x - 1) * int'(l.s) - int'(l.p);
                     e.pad   = (e.row < 0) || (e.row >= int'(l.iy))
                               || (e.col < 0) || (e.col >= int'(l.ix));
                     e.waddr = 16'(((f - 1) * int'(l.nif) + i - 1) * int'(l.k) + ky);
                     exp_q.push_back(e);
                  end
               end
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   task automatic check_step();
      step_t e;
      if (step_idx >= exp_q.size()) begin
         report_mismatch($sformatf("busy high after %0d predicted steps", exp_q.size()));
      end else begin
         e = exp_q[step_idx];
         assert ({ox_start, oy_start, of_start, if_idx} == {e.ox_s, e.oy_s, e.of_s, e.if_i})
            else report_mismatch($sformatf(
               "step %0d starts %0d %0d %0d %0d, expected %0d %0d %0d %0d",
               step_idx, ox_start, oy_start, of_start, if_idx, e.ox_s, e.oy_s, e.of_s, e.if_i));
         assert ({pox, poy, pof, row_base} == {e.pox, e.poy, e.pof, e.rb})
            else report_mismatch($sformatf(
               "step %0d sizes %0d %0d %0d base %0d, expected %0d %0d %0d %0d",
               step_idx, pox, poy, pof, row_base, e.pox, e.poy, e.pof, e.rb));
         assert (done == (step_idx == exp_q.size() - 1))
            else report_mismatch($sformatf("done is %0b on step %0d of %0d", done, step_idx,
               exp_q.size()));
         step_idx++;
      end
   endtask

   task automatic check_fetch();
      step_t e;
      e = exp_q[fetch_idx];
      assert (int'(fetch_row) == e.row && int'(fetch_col) == e.col && fetch_pad == e.pad)
         else report_mismatch($sformatf(
            "record %0d row %0d col %0d pad %0b, expected %0d %0d %0b",
            fetch_idx, fetch_row, fetch_col, fetch_pad, e.row, e.col, e.pad));
      assert (weight_addr == e.waddr)
         else report_mismatch($sformatf("record %0d weight_addr %0d, expected %0d",
            fetch_idx, weight_addr, e.waddr));
      fetch_idx++;
   endtask

   // sampled mid cycle away from the driving edge
   always @(negedge clk) begin
      if (!reset) begin
         assert (!done || busy) else report_mismatch("done outside a run");
         if (busy) begin
            if (done)
               done_count++;
            check_step();
         end
         if (fetch_valid)
            check_fetch();
      end
   end

   assert property (@(posedge clk) disable iff (reset) fetch_valid == $past(busy))
      else report_mismatch("fetch_valid does not trail the row steps by one cycle");
   assert property (@(posedge clk) disable iff (reset) $past(done) |-> !busy)
      else report_mismatch("busy still high after done");
   assert property (@(posedge clk) disable iff (reset) $past(start && !busy) |-> busy)
      else report_mismatch("busy did not rise after start");

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   task automatic run_layer(input layer_t l);
      int n_steps;
      n_steps = predicted_steps(l);
      build_model(l);
      step_idx   = 0;
      fetch_idx  = 0;
      done_count = 0;
      @(posedge clk);
      mode  <= l.md;
      of    <= l.of;
      ox    <= l.ox;
      oy    <= l.oy;
      ix    <= l.ix;
      iy    <= l.iy;
      nif   <= l.nif;
      k     <= l.k;
      s     <= l.s;
      p     <= l.p;
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      // stray start while busy
      if (n_steps > 4) begin
         @(posedge clk);
         start <= 1'b1;
         @(posedge clk);
         start <= 1'b0;
      end
      while (done_count == 0)
         @(posedge clk);
      @(posedge clk);
      @(negedge clk);
      assert (step_idx == n_steps && fetch_idx == n_steps && done_count == 1)
         else report_mismatch($sformatf("%0d steps %0d records %0d done, expected %0d %0d 1",
            step_idx, fetch_idx, done_count, n_steps, n_steps));
   endtask

   initial begin
      int total;
      reset = 1'b1;
      start = 1'b0;
      mode  = 1'b0;
      of    = '0;
      ox    = '0;
      oy    = '0;
      ix    = '0;
      iy    = '0;
      nif   = '0;
      k     = '0;
      s     = '0;
      p     = '0;
      void'($urandom(32'haa68d9b9));
      // edge tiles in x and output channels with negative rows
      layers[0] = make_layer(1'b0, 100, 40, 7, 40, 8, 3, 3, 1, 1);
      // mode 1 with rows and columns past the input map
      layers[1] = make_layer(1'b1, 130, 33, 6, 20, 5, 2, 3, 2, 0);
      // second run of the first layer
      layers[2] = layers[0];
      for (int n = 3; n < NUM_LAYERS; n++) begin
         layers[n] = make_layer(1'($urandom_range(1, 0)), $urandom_range(200, 1),
            $urandom_range(70, 1), $urandom_range(10, 1), $urandom_range(80, 1),
            $urandom_range(24, 1), $urandom_range(4, 1), $urandom_range(5, 1),
            $urandom_range(3, 1), $urandom_range(2, 0));
      end
      total = 200;
      for (int n = 0; n < NUM_LAYERS; n++)
         total += 4 * predicted_steps(layers[n]);
      budget_cycles = total;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      assert (busy == 1'b0 && done == 1'b0 && fetch_valid == 1'b0)
         else report_mismatch("busy, done or fetch_valid set after reset");
      for (int n = 0; n < NUM_LAYERS; n++)
         run_layer(layers[n]);
      $display("STATUS: PASS");
      $finish;
   end

   // watchdog
   initial begin
      wait (budget_cycles > 0);
      repeat (budget_cycles) @(posedge clk);
      $display("timeout: the runs did not finish within %0d cycles", budget_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- list.f
hdl/conv_tiling_pkg.sv
hdl/tile_if.sv
hdl/row_step_if.sv
hdl/conv_tiling.sv
hdl/kernel_row_sequencer.sv
hdl/input_window_calc.sv
hdl/weight_addr_calc.sv
hdl/conv_tile_engine.sv
sim/tb_conv_tile_engine.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_conv_tile_engine -f list.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
   exit 0
fi
echo "pass message not found"
exit 1
